// File: src/arithPkg.sv
package arithPkg;

	// operation select for the inc/dec stage
	typedef enum logic [1:0] {
		opInc = 2'd0, // A + 1
		opDec = 2'd1, // A - 1
		opNeg = 2'd2, // two's complement
		opAbs = 2'd3  // magnitude of signed A
	} opCode_t;

	// defaults picked up by the top level
	localparam int defaultWidth = 8; // bits per operand word

	// prefix tree variant
	// 0 serial chain, 1 brent-kung, 2 sklansky
	localparam int defaultSpeed = 0;

endpackage

// File: src/PrefixAnd.sv
`timescale 1ns/1ps

// PO[i] = &PI[i:0], structure picked by speed
module PrefixAnd #(
	parameter int width = arithPkg::defaultWidth, // bits in the word
	parameter int speed = arithPkg::defaultSpeed  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] PO  // prefix and of PI[i:0]
);

	localparam int m = $clog2(width); // log depth of the trees

	if (speed == 0) begin : slowPrefix
		logic [width-1:0] pt; // running and, one gate per bit

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign pt[i] = pt[i-1] & PI[i]; // ripples across the word
		end
		assign PO = pt;

	end else if (speed == 1) begin : mediumPrefix
		// levels 1..m reduce upward, levels m+1..2m-1 fill in the gaps
		logic [width-1:0] pt [0:2*m-1];

		assign pt[0] = PI;

		// up-sweep
		for (genvar l = 1; l <= m; l++) begin : upLevels
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i + 1) % (2**l) == 0) begin : black
					// joins two aligned blocks of 2**(l-1)
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// down-sweep, span halves each level
		for (genvar l = m - 1; l >= 1; l--) begin : downLevels
			for (genvar i = 0; i < width; i++) begin : bits
				if (((i + 1) % (2**l) == 2**(l-1)) && (i >= 2**l)) begin : black
					// lower neighbour already holds a full prefix
					assign pt[2*m-l][i] = pt[2*m-l-1][i] & pt[2*m-l-1][i - 2**(l-1)];
				end else begin : white
					assign pt[2*m-l][i] = pt[2*m-l-1][i];
				end
			end
		end

		assign PO = pt[2*m-1]; // last level

	end else if (speed == 2) begin : fastPrefix
		// block of 2**l doubles each level, high fanout
		logic [width-1:0] pt [0:m];

		assign pt[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				if (((i >> (l - 1)) & 1) == 1) begin : black
					// top bit of the lower half block
					assign pt[l][i] = pt[l-1][i] & pt[l-1][((i >> l) << l) + 2**(l-1) - 1];
				end else begin : white
					assign pt[l][i] = pt[l-1][i]; // lower half passes
				end
			end
		end

		assign PO = pt[m];

	end else begin : badSpeed
		$error("PrefixAnd speed %0d out of range", speed);
	end

endmodule

// File: src/Inc.sv
`timescale 1ns/1ps

// Z = A + 1 mod 2**width
module Inc #(
	parameter int width = arithPkg::defaultWidth, // bits in the word
	parameter int speed = arithPkg::defaultSpeed  // prefix variant
) (
	input  logic [width-1:0] A, // operand
	output logic [width-1:0] Z  // A plus one
);

	logic [width-1:0] po; // all of A[i:0] one

	// carry into bit i+1 is just the prefix and of A
	PrefixAnd #(
		.width(width),
		.speed(speed)
	) prefixUnit (
		.PI(A),
		.PO(po)
	);

	// flip bit 0 always
	// flip bit i when the carry ripples that far
	assign Z = A ^ {po[width-2:0], 1'b1};

	// top bit of po is the all-ones case, covered by the flag logic upstairs

endmodule

// File: src/Dec.sv
`timescale 1ns/1ps

// Z = A - 1 mod 2**width
module Dec #(
	parameter int width = arithPkg::defaultWidth, // bits in the word
	parameter int speed = arithPkg::defaultSpeed  // prefix variant
) (
	input  logic [width-1:0] A, // operand
	output logic [width-1:0] Z  // A minus one
);

	logic [width-1:0] aInv; // ones where A has zeros
	logic [width-1:0] po;   // all of A[i:0] zero

	assign aInv = ~A;

	PrefixAnd #(
		.width(width),
		.speed(speed)
	) prefixUnit (
		.PI(aInv),
		.PO(po)
	);

	// bit 0 always flips, bit i flips when every lower bit is zero (borrow)
	assign Z = A ^ {po[width-2:0], 1'b1};

endmodule

// File: src/IncDecOp.sv
`timescale 1ns/1ps

// combinational inc / dec / neg / abs with wrap and zero flags
module IncDecOp #(
	parameter int width = arithPkg::defaultWidth, // bits in the word
	parameter int speed = arithPkg::defaultSpeed  // prefix variant
) (
	input  arithPkg::opCode_t op,      // operation select
	input  logic [width-1:0]  operand, // source word
	output logic [width-1:0]  result,  // selected result
	output logic              wrap,    // result left the number range
	output logic              zero     // result all zeros
);

	logic [width-1:0] incIn;  // operand, or its complement for neg/abs
	logic [width-1:0] incOut; // incIn + 1
	logic [width-1:0] decOut; // operand - 1
	logic             allOnes;  // operand = 2**width - 1
	logic             allZeros; // operand = 0
	logic             signIn;   // operand negative when signed
	logic             mostNeg;  // operand = -2**(width-1)

	// -A = ~A + 1, so the incrementer does double duty
	assign incIn = (op == arithPkg::opInc) ? operand : ~operand;

	Inc #(
		.width(width),
		.speed(speed)
	) incUnit (
		.A(incIn),
		.Z(incOut)
	);

	Dec #(
		.width(width),
		.speed(speed)
	) decUnit (
		.A(operand),
		.Z(decOut)
	);

	// operand classification for the wrap flag
	assign allOnes  = &operand;
	assign allZeros = ~|operand;
	assign signIn   = operand[width-1];
	assign mostNeg  = signIn & ~|operand[width-2:0]; // 100..0

	always_comb begin
		result = operand; // pass through unless replaced
		wrap   = 1'b0;
		case (op)
			arithPkg::opInc: begin
				result = incOut;
				wrap   = allOnes; // rolls over to zero
			end
			arithPkg::opDec: begin
				result = decOut;
				wrap   = allZeros; // borrows out to all ones
			end
			arithPkg::opNeg: begin
				result = incOut;  // ~operand + 1
				wrap   = mostNeg; // has no positive twin
			end
			arithPkg::opAbs: begin
				result = signIn ? incOut : operand; // negate only negatives
				wrap   = mostNeg;
			end
		endcase
	end

	assign zero = ~|result;

endmodule

// File: src/IncDecStage.sv
`timescale 1ns/1ps

// one-entry registered stage around IncDecOp, valid/ready on both sides
module IncDecStage #(
	parameter int width = arithPkg::defaultWidth, // bits in the word
	parameter int speed = arithPkg::defaultSpeed  // prefix variant
) (
	input  logic              clk,
	input  logic              reset,    // sync, active high
	input  logic              inValid,  // source has a word
	output logic              inReady,  // stage can take it
	input  arithPkg::opCode_t op,       // operation select
	input  logic [width-1:0]  operand,  // source word
	output logic              outValid, // output register full
	input  logic              outReady, // sink takes the word
	output logic [width-1:0]  result,   // registered result
	output logic              wrap,     // registered wrap flag
	output logic              zero      // registered zero flag
);

	logic             accept;   // input transfer this edge
	logic [width-1:0] opResult; // combinational result
	logic             opWrap;
	logic             opZero;

	IncDecOp #(
		.width(width),
		.speed(speed)
	) opUnit (
		.op(op),
		.operand(operand),
		.result(opResult),
		.wrap(opWrap),
		.zero(opZero)
	);

	// take a new word when empty, or when the held one leaves this cycle
	assign inReady = ~outValid | outReady;
	assign accept  = inValid & inReady;

	// occupancy flag
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid; // refill, or drain to empty
		end
		// stalled: hold full
	end

	// payload regs, only loaded on accept so they hold under back-pressure
	always_ff @(posedge clk) begin
		if (accept) begin
			result <= opResult;
			wrap   <= opWrap;
			zero   <= opZero;
		end
	end

endmodule

// File: tb/IncDecStage_checker.sv
`timescale 1ns/1ps

// handshake rules of the stage, bound into every IncDecStage
module IncDecStage_checker #(
	parameter int width = arithPkg::defaultWidth
) (
	input logic             clk,
	input logic             reset,
	input logic             inValid,
	input logic             inReady,
	input logic             outValid,
	input logic             outReady,
	input logic [width-1:0] result,
	input logic             wrap,
	input logic             zero
);

	int failCount = 0; // summed by the testbench at the end

	// sync reset empties the register
	emptyAfterReset: assert property (@(posedge clk) reset |=> !outValid)
		else begin $error("outValid high after a reset cycle"); failCount++; end

	holdWhileStalled: assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(result) && $stable(wrap) && $stable(zero)))
		else begin $error("output moved while stalled"); failCount++; end

	noReadyWhenStalled: assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |-> !inReady)
		else begin $error("inReady high while stalled"); failCount++; end

	// one cycle latency
	validAfterAccept: assert property (@(posedge clk) disable iff (reset)
		(inValid && inReady) |=> outValid)
		else begin $error("no outValid one cycle after accept"); failCount++; end

endmodule

bind IncDecStage IncDecStage_checker #(.width(width)) handshakeCheck (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.result(result),
	.wrap(wrap),
	.zero(zero)
);

// File: tb/IncDecStageTb.sv
`timescale 1ns/1ps

module IncDecStageTb;

	localparam int width    = 8;
	localparam int speed    = 1;  // brent-kung
	localparam int maxVec   = 64;
	localparam int burstLen = 12; // first vectors go back-to-back, no stalls

	logic              clk;
	logic              reset;
	logic              inValid;
	logic              inReady;
	arithPkg::opCode_t op;
	logic [width-1:0]  operand;
	logic              outValid;
	logic              outReady;
	logic [width-1:0]  result;
	logic              wrap;
	logic              zero;

	logic [1:0]       vecOp      [0:maxVec-1];
	logic [width-1:0] vecOperand [0:maxVec-1];
	logic [width-1:0] vecResult  [0:maxVec-1];
	logic             vecWrap    [0:maxVec-1];
	logic             vecZero    [0:maxVec-1];

	int nVec;       // vectors loaded
	int sent;       // accepted by the DUT
	int done;       // came out and compared
	int errors;
	int mismatches;
	int cycles;
	int limit;      // timeout in cycles
	int expQ [$];   // vector indices in flight

	logic             holding;   // word offered but not yet taken
	logic             took;
	logic             gave;
	logic             tookLast;
	logic             burstNow;
	logic             prevStall; // stalled at the last edge
	logic [width-1:0] prevResult;
	logic             prevWrap;
	logic             prevZero;

	IncDecStage #(
		.width(width),
		.speed(speed)
	) IncDecStage_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.op(op),
		.operand(operand),
		.outValid(outValid),
		.outReady(outReady),
		.result(result),
		.wrap(wrap),
		.zero(zero)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// lines that do not parse as five hex fields are skipped
	task automatic loadVectors;
		int fd;
		int code;
		string line;
		logic [31:0] fOp;
		logic [31:0] fOperand;
		logic [31:0] fResult;
		logic [31:0] fWrap;
		logic [31:0] fZero;
		nVec = 0;
		fd = $fopen("tb/incdec_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/incdec_golden.txt");
			errors++;
		end else begin
			while (!$feof(fd) && nVec < maxVec) begin
				code = $fgets(line, fd);
				if (code > 0 && $sscanf(line, "%h %h %h %h %h", fOp, fOperand, fResult,
						fWrap, fZero) == 5) begin
					vecOp[nVec]      = fOp[1:0];
					vecOperand[nVec] = fOperand[width-1:0];
					vecResult[nVec]  = fResult[width-1:0];
					vecWrap[nVec]    = fWrap[0];
					vecZero[nVec]    = fZero[0];
					nVec++;
				end
			end
			$fclose(fd);
		end
	endtask

	// falling edge drive, word held until the DUT takes it
	task automatic driveInputs;
		burstNow = (sent < burstLen);
		outReady = burstNow ? 1'b1 : ($urandom % 3 != 0);
		if (!holding) begin
			if (sent < nVec) begin
				inValid = burstNow ? 1'b1 : ($urandom % 4 != 0); // random gaps later on
				op      = arithPkg::opCode_t'(vecOp[sent]);
				operand = vecOperand[sent];
			end else begin
				inValid = 1'b0;
			end
		end
	endtask

	task automatic checkVector(input int idx);
		logic ok;
		ok = 1'b1;
		assert (result == vecResult[idx]) else begin
			$display("FAILED t=%0t result got %h expected %h", $time, result, vecResult[idx]);
			ok = 1'b0;
		end
		assert (wrap == vecWrap[idx]) else begin
			$display("FAILED t=%0t wrap got %b expected %b", $time, wrap, vecWrap[idx]);
			ok = 1'b0;
		end
		assert (zero == vecZero[idx]) else begin
			$display("FAILED t=%0t zero got %b expected %b", $time, zero, vecZero[idx]);
			ok = 1'b0;
		end
		if (!ok) mismatches++;
		$display("vector %0d op %0d operand %h -> result %h wrap %b zero %b %s", idx,
			vecOp[idx], vecOperand[idx], result, wrap, zero, ok ? "ok" : "mismatch");
	endtask

	// values must not move while the sink stalls
	task automatic checkHeld;
		assert (result == prevResult) else begin
			$display("FAILED t=%0t result got %h expected held %h", $time, result, prevResult);
			errors++;
		end
		assert (wrap == prevWrap && zero == prevZero) else begin
			$display("FAILED t=%0t wrap/zero got %b%b expected held %b%b", $time, wrap, zero,
				prevWrap, prevZero);
			errors++;
		end
	endtask

	initial begin
		void'($urandom(32'h14a5));
		reset      = 1'b1;
		inValid    = 1'b0;
		outReady   = 1'b0;
		op         = arithPkg::opInc;
		operand    = '0;
		sent       = 0;
		done       = 0;
		errors     = 0;
		mismatches = 0;
		cycles     = 0;
		holding    = 1'b0;
		tookLast   = 1'b0;
		prevStall  = 1'b0;
		burstNow   = 1'b0;
		loadVectors();
		limit = nVec * 8 + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		while (done < nVec && cycles < limit) begin
			driveInputs();
			@(posedge clk); // registered outputs still hold pre-edge values here
			cycles++;
			took = inValid && inReady;
			gave = outValid && outReady;
			if (burstNow) begin
				assert (inReady) else begin
					$display("FAILED t=%0t inReady got %b expected 1", $time, inReady);
					errors++;
				end
				if (tookLast) begin
					assert (outValid) else begin
						$display("FAILED t=%0t outValid got %b expected 1", $time, outValid);
						errors++;
					end
				end
			end
			if (prevStall) checkHeld();
			if (gave) begin
				if (expQ.size() == 0) begin
					$display("output transfer at t=%0t with no input outstanding", $time);
					errors++;
				end else begin
					checkVector(expQ.pop_front());
					done++;
				end
			end
			if (took) begin
				expQ.push_back(sent);
				sent++;
			end
			holding    = inValid && !took;
			tookLast   = took;
			prevStall  = outValid && !outReady;
			prevResult = result;
			prevWrap   = wrap;
			prevZero   = zero;
			@(negedge clk);
		end

		if (done < nVec) begin
			$display("timeout after %0d cycles, only %0d of %0d vectors came out", cycles, done,
				nVec);
			errors++;
		end
		if (IncDecStage_inst.handshakeCheck.failCount != 0) begin
			$display("handshake checker flagged %0d violations",
				IncDecStage_inst.handshakeCheck.failCount);
			errors += IncDecStage_inst.handshakeCheck.failCount;
		end
		$display("%0d of %0d vectors checked, %0d mismatched, %0d other errors", done, nVec,
			mismatches, errors);
		if (errors == 0 && mismatches == 0 && nVec > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb/incdec_golden.txt
// op operand result wrap zero, all hex
// op 0 inc, 1 dec, 2 neg, 3 abs
0 00 01 0 0
0 01 02 0 0
0 0f 10 0 0
0 7f 80 0 0
0 80 81 0 0
0 a5 a6 0 0
0 fe ff 0 0
0 ff 00 1 1
0 3c 3d 0 0
1 00 ff 1 0
1 01 00 0 1
1 02 01 0 0
1 80 7f 0 0
1 81 80 0 0
1 ff fe 0 0
1 f0 ef 0 0
1 5a 59 0 0
1 10 0f 0 0
2 00 00 0 1
2 01 ff 0 0
2 7f 81 0 0
2 80 80 1 0
2 81 7f 0 0
2 ff 01 0 0
2 c3 3d 0 0
2 40 c0 0 0
3 00 00 0 1
3 01 01 0 0
3 7f 7f 0 0
3 80 80 1 0
3 81 7f 0 0
3 ff 01 0 0
3 9c 64 0 0
3 55 55 0 0

// File: sim.f
src/arithPkg.sv
src/PrefixAnd.sv
src/Inc.sv
src/Dec.sv
src/IncDecOp.sv
src/IncDecStage.sv
tb/IncDecStage_checker.sv
tb/IncDecStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the IncDecStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
	-f sim.f \
	--top-module IncDecStageTb \
	-o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

# keep going past assertion errors so the testbench prints its summary
output=$(./obj_dir/simv +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
else
	echo "pass message not found"
	exit 1
fi
